//--- design/conv_loop_pkg.sv
package conv_loop_pkg;

	////////////////////////////////////////////////////////////
	// Stream sizes
	////////////////////////////////////////////////////////////

	// Pixel sample width
	localparam int DATA_WIDTH = 16;

	// Channel slots, also the number of delay taps
	localparam int CHANNELS = 4;

	// Samples per row slot, also the depth of each delay line
	localparam int ROW_LEN = 8;

	// Real pixels at the start of a slot, the rest is padding
	localparam int ACTIVE_LEN = 6;

	// Derived counter widths
	localparam int COL_W = $clog2(ROW_LEN);
	localparam int CHAN_W = $clog2(CHANNELS);

	////////////////////////////////////////////////////////////
	// Sample record
	////////////////////////////////////////////////////////////

	// One sample as it moves down the delay chain.
	// Bubbles keep valid low and travel with the data.
	typedef struct packed {
		// Sample present on this cycle
		logic valid;
		// Column below ACTIVE_LEN
		logic active;
		// Position within the row slot
		logic [COL_W-1:0] col;
		// Pixel value
		logic [DATA_WIDTH-1:0] data;
	} pixel_t;

	////////////////////////////////////////////////////////////
	// Channel selector FSM
	////////////////////////////////////////////////////////////

	typedef enum logic {
		// Waiting for a valid sample on tap 0
		SEL_IDLE = 1'b0,
		// Walking slot by slot across the taps
		SEL_SCAN = 1'b1
	} sel_state_t;

endpackage

//--- design/pixel_framer.sv
`timescale 1ns/100ps

module pixel_framer (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                valid_in,
	input  logic [conv_loop_pkg::DATA_WIDTH-1:0] pxl_in,
	output conv_loop_pkg::pixel_t               pix
);

	// Column of the next valid sample
	logic [conv_loop_pkg::COL_W-1:0] col_cnt;
	logic                            col_last;

	// Registered sample fields
	logic                                 pix_valid;
	logic                                 pix_active;
	logic [conv_loop_pkg::COL_W-1:0]      pix_col;
	logic [conv_loop_pkg::DATA_WIDTH-1:0] pix_data;

	assign col_last = (col_cnt == conv_loop_pkg::COL_W'(conv_loop_pkg::ROW_LEN - 1));

	////////////////////////////////////////////////////////////
	// Column counter
	////////////////////////////////////////////////////////////

	// Only valid samples move the counter, gaps hold it
	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt <= '0;
		end else if (valid_in) begin
			if (col_last) begin
				col_cnt <= '0;
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Sample register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_valid  <= 1'b0;
			pix_active <= 1'b0;
		end else begin
			pix_valid  <= valid_in;
			// Padding columns stay inactive
			pix_active <= valid_in && (int'(col_cnt) < conv_loop_pkg::ACTIVE_LEN);
		end
	end

	// Payload follows the valid strobe
	always_ff @(posedge clk) begin
		pix_col  <= col_cnt;
		pix_data <= pxl_in;
	end

	always_comb begin
		pix.valid  = pix_valid;
		pix.active = pix_active;
		pix.col    = pix_col;
		pix.data   = pix_data;
	end

endmodule

//--- design/line_buffer.sv
`timescale 1ns/100ps

module line_buffer #(
	parameter int DEPTH = 8
) (
	input  logic                  clk,
	input  logic                  reset,
	input  conv_loop_pkg::pixel_t din,
	output conv_loop_pkg::pixel_t dout
);

	// Pointer needs at least one bit even for a single entry
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Sample storage and its separate valid flags
	conv_loop_pkg::pixel_t mem [DEPTH];
	logic [DEPTH-1:0]      vld;

	// Oldest entry, also the slot written this cycle
	logic [PTR_W-1:0] ptr;
	logic             ptr_last;

	assign ptr_last = (ptr == PTR_W'(DEPTH - 1));

	////////////////////////////////////////////////////////////
	// Circular pointer
	////////////////////////////////////////////////////////////

	// Steps every clock, bubbles included
	always_ff @(posedge clk) begin
		if (reset) begin
			ptr <= '0;
		end else if (ptr_last) begin
			ptr <= '0;
		end else begin
			ptr <= ptr + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Read oldest, write newest in its place
	////////////////////////////////////////////////////////////

	// Valid flags cleared on reset so old contents come out as bubbles
	always_ff @(posedge clk) begin
		if (reset) begin
			vld <= '0;
		end else begin
			vld[ptr] <= din.valid;
		end
	end

	always_ff @(posedge clk) begin
		mem[ptr] <= din;
	end

	// Oldest entry leaves before it is overwritten on this edge
	always_comb begin
		dout       = mem[ptr];
		dout.valid = vld[ptr];
	end

endmodule

//--- design/channel_selector.sv
`timescale 1ns/100ps

module channel_selector (
	input  logic                                                clk,
	input  logic                                                reset,
	input  conv_loop_pkg::pixel_t [conv_loop_pkg::CHANNELS-1:0] taps,
	output logic [conv_loop_pkg::DATA_WIDTH-1:0]                pxl_out,
	output logic                                                valid_out,
	output logic [conv_loop_pkg::CHAN_W-1:0]                    chan_out
);

	conv_loop_pkg::sel_state_t state;

	// Tap being drained and position inside its slot
	logic [conv_loop_pkg::CHAN_W-1:0] chan;
	logic [conv_loop_pkg::COL_W-1:0]  col_cnt;

	// Counter values after taking one sample
	logic [conv_loop_pkg::CHAN_W-1:0] chan_nxt;
	logic [conv_loop_pkg::COL_W-1:0]  col_nxt;
	logic                             slot_end;
	logic                             chan_last;

	// Sample seen this cycle
	conv_loop_pkg::pixel_t cur;

	////////////////////////////////////////////////////////////
	// Tap select and counter stepping
	////////////////////////////////////////////////////////////

	// Channel sits at 0 while idle so only tap 0 is watched
	assign cur = taps[chan];

	assign slot_end  = (col_cnt == conv_loop_pkg::COL_W'(conv_loop_pkg::ROW_LEN - 1));
	assign chan_last = (chan == conv_loop_pkg::CHAN_W'(conv_loop_pkg::CHANNELS - 1));

	// Move to the next tap after a full row slot
	always_comb begin
		chan_nxt = chan;
		col_nxt  = col_cnt + 1'b1;
		if (slot_end) begin
			col_nxt = '0;
			if (chan_last) begin
				chan_nxt = '0;
			end else begin
				chan_nxt = chan + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= conv_loop_pkg::SEL_IDLE;
			chan    <= '0;
			col_cnt <= '0;
		end else begin
			case (state)
				conv_loop_pkg::SEL_IDLE: begin
					// First sample of a burst is consumed right away
					if (cur.valid) begin
						state   <= conv_loop_pkg::SEL_SCAN;
						chan    <= chan_nxt;
						col_cnt <= col_nxt;
					end
				end
				conv_loop_pkg::SEL_SCAN: begin
					if (cur.valid) begin
						chan    <= chan_nxt;
						col_cnt <= col_nxt;
					end else begin
						// Bubble on the current tap ends the burst
						state   <= conv_loop_pkg::SEL_IDLE;
						chan    <= '0;
						col_cnt <= '0;
					end
				end
				default: begin
					state   <= conv_loop_pkg::SEL_IDLE;
					chan    <= '0;
					col_cnt <= '0;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////

	// Padding and bubbles come out as zero with valid_out low
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
			pxl_out   <= '0;
			chan_out  <= '0;
		end else begin
			chan_out <= chan;
			if (cur.valid && cur.active) begin
				valid_out <= 1'b1;
				pxl_out   <= cur.data;
			end else begin
				valid_out <= 1'b0;
				pxl_out   <= '0;
			end
		end
	end

endmodule

//--- design/conv_loop_data_in.sv
`timescale 1ns/100ps

module conv_loop_data_in (
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 valid_in,
	input  logic [conv_loop_pkg::DATA_WIDTH-1:0] pxl_in,
	output logic [conv_loop_pkg::DATA_WIDTH-1:0] pxl_out,
	output logic                                 valid_out,
	output logic [conv_loop_pkg::CHAN_W-1:0]     chan_out
);

	// Tap k lags tap 0 by k row slots
	wire conv_loop_pkg::pixel_t [conv_loop_pkg::CHANNELS-1:0] taps;

	////////////////////////////////////////////////////////////
	// Input framing
	////////////////////////////////////////////////////////////

	// Drives tap 0
	pixel_framer i_pixel_framer (
		.clk     (clk),
		.reset   (reset),
		.valid_in(valid_in),
		.pxl_in  (pxl_in),
		.pix     (taps[0])
	);

	////////////////////////////////////////////////////////////
	// Delay chain
	////////////////////////////////////////////////////////////

	// One row slot of delay per stage
	for (genvar k = 0; k < conv_loop_pkg::CHANNELS - 1; k++) begin : g_delay
		line_buffer #(
			.DEPTH(conv_loop_pkg::ROW_LEN)
		) i_line_buffer (
			.clk  (clk),
			.reset(reset),
			.din  (taps[k]),
			.dout (taps[k+1])
		);
	end

	////////////////////////////////////////////////////////////
	// Tap selection
	////////////////////////////////////////////////////////////

	channel_selector i_channel_selector (
		.clk      (clk),
		.reset    (reset),
		.taps     (taps),
		.pxl_out  (pxl_out),
		.valid_out(valid_out),
		.chan_out (chan_out)
	);

endmodule

//--- test/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

	// Pixel source state
	logic [31:0] lfsr_state = 32'h009e_bac7;

	// Valid input samples of the current burst, position is the index n
	logic [conv_loop_pkg::DATA_WIDTH-1:0] burst_q[$];

	// Bumped each time the model starts over
	int burst_id = 0;

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per pixel bit
	function automatic logic [conv_loop_pkg::DATA_WIDTH-1:0] random_pixel();
		logic [conv_loop_pkg::DATA_WIDTH-1:0] px;
		px = '0;
		for (int i = 0; i < conv_loop_pkg::DATA_WIDTH; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			px = {px[conv_loop_pkg::DATA_WIDTH-2:0], lfsr_state[0]};
		end
		return px;
	endfunction

	// Input index feeding output pixel m
	function automatic int expected_index(input int m);
		int g;
		g = m / (conv_loop_pkg::ACTIVE_LEN * conv_loop_pkg::CHANNELS);
		return g * conv_loop_pkg::CHANNELS * conv_loop_pkg::ROW_LEN
			+ (m % conv_loop_pkg::ACTIVE_LEN);
	endfunction

	// Channel slot of output pixel m
	function automatic logic [conv_loop_pkg::CHAN_W-1:0] expected_chan(input int m);
		return conv_loop_pkg::CHAN_W'((m / conv_loop_pkg::ACTIVE_LEN) % conv_loop_pkg::CHANNELS);
	endfunction

	// Output pixels for a burst of whole row groups
	function automatic int expected_total(input int n);
		return (n / (conv_loop_pkg::CHANNELS * conv_loop_pkg::ROW_LEN))
			* conv_loop_pkg::CHANNELS * conv_loop_pkg::ACTIVE_LEN;
	endfunction

	function automatic void clear_model();
		burst_q.delete();
		burst_id++;
	endfunction

`endif

//--- test/conv_loop_data_in_tb.sv
`timescale 1ns/100ps

module conv_loop_data_in_tb;

	// Stimulus lengths in clock cycles
	localparam int RESET_CYCLES = 5;
	localparam int IDLE_LEN = 20;
	localparam int BURST_LEN = 3 * conv_loop_pkg::CHANNELS * conv_loop_pkg::ROW_LEN;
	localparam int GAP_LEN = conv_loop_pkg::CHANNELS * conv_loop_pkg::ROW_LEN + 2;
	localparam int PART_LEN = 40;
	localparam int PIPE_DEPTH = 2 + conv_loop_pkg::CHANNELS * conv_loop_pkg::ROW_LEN;
	localparam int TEST_SUM = RESET_CYCLES + IDLE_LEN + (BURST_LEN + PIPE_DEPTH)
		+ (GAP_LEN + BURST_LEN + PIPE_DEPTH)
		+ (PART_LEN + RESET_CYCLES + BURST_LEN + 2 * PIPE_DEPTH);
	localparam int CYCLE_LIMIT = 2 * (TEST_SUM + PIPE_DEPTH);

	logic                                 clk = 1'b0;
	logic                                 reset;
	logic                                 valid_in;
	logic [conv_loop_pkg::DATA_WIDTH-1:0] pxl_in;
	logic [conv_loop_pkg::DATA_WIDTH-1:0] pxl_out;
	logic                                 valid_out;
	logic [conv_loop_pkg::CHAN_W-1:0]     chan_out;

	// Error counts, one per writing process
	int check_errs = 0;
	int prop_errs = 0;
	int flow_errs = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycle_cnt = 0;

	// Output side of the model, owned by the checker
	int                               out_cnt = 0;
	int                               seen_id = 0;
	int                               run_len = 0;
	logic [conv_loop_pkg::CHAN_W-1:0] run_chan = '0;
	logic                             rst_q = 1'b0;

	`include "tb_model.svh"

	always #2 clk = ~clk;

	conv_loop_data_in i_conv_loop_data_in (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.pxl_in   (pxl_in),
		.pxl_out  (pxl_out),
		.valid_out(valid_out),
		.chan_out (chan_out)
	);

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Padding and bubbles leave pxl_out at zero
	zero_when_invalid: assert property (@(posedge clk) disable iff (reset)
		!valid_out |-> pxl_out == '0)
	else begin
		$display("ERR %0t pxl_out expected 0 got %h", $time, $sampled(pxl_out));
		prop_errs++;
	end

	// Reset value seen by the DUT on this edge
	always @(posedge clk) begin
		rst_q <= reset;
	end

	always @(negedge clk) begin
		int idx;
		if (seen_id != burst_id) begin
			seen_id = burst_id;
			out_cnt = 0;
			run_len = 0;
		end
		if (rst_q) begin
			reset_clears: assert (valid_out == 1'b0) else begin
				$display("ERR %0t valid_out expected 0 got %b", $time, valid_out);
				check_errs++;
			end
		end
		if (!reset && valid_out) begin
			idx = expected_index(out_cnt);
			known_input: assert (idx < burst_q.size()) else begin
				$display("Output pixel %0d at %0t has no matching input sample", out_cnt, $time);
				check_errs++;
			end
			if (idx < burst_q.size()) begin
				pixel_match: assert (pxl_out == burst_q[idx]) else begin
					$display("ERR %0t pxl_out expected %h got %h", $time, burst_q[idx], pxl_out);
					check_errs++;
				end
			end
			chan_match: assert (chan_out == expected_chan(out_cnt)) else begin
				$display("ERR %0t chan_out expected %0d got %0d", $time,
					expected_chan(out_cnt), chan_out);
				check_errs++;
			end
			// Each channel slot carries exactly ACTIVE_LEN pixels
			if (run_len != 0 && chan_out != run_chan) begin
				slot_full: assert (run_len == conv_loop_pkg::ACTIVE_LEN) else begin
					$display("Channel %0d slot ended after %0d pixels at %0t", run_chan, run_len, $time);
					check_errs++;
				end
				run_len = 0;
			end
			run_chan = chan_out;
			run_len++;
			slot_short: assert (run_len <= conv_loop_pkg::ACTIVE_LEN) else begin
				$display("Channel %0d slot exceeds %0d pixels at %0t", run_chan,
					conv_loop_pkg::ACTIVE_LEN, $time);
				check_errs++;
			end
			out_cnt++;
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, run did not complete", cycle_cnt);
			$display("Done: errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	function automatic int total_errors();
		return check_errs + prop_errs + flow_errs;
	endfunction

	task automatic idle_cycles(input int count);
		repeat (count) begin
			@(posedge clk);
			valid_in <= 1'b0;
			pxl_in   <= '0;
		end
	endtask

	task automatic drive_samples(input int count);
		logic [conv_loop_pkg::DATA_WIDTH-1:0] px;
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			px = random_pixel();
			valid_in <= 1'b1;
			pxl_in   <= px;
			burst_q.push_back(px);
		end
		@(posedge clk);
		valid_in <= 1'b0;
		pxl_in   <= '0;
	endtask

	task automatic apply_reset(input int cycles);
		@(posedge clk);
		reset    <= 1'b1;
		valid_in <= 1'b0;
		clear_model();
		repeat (cycles) @(posedge clk);
		reset <= 1'b0;
	endtask

	// Waits for the burst's output pixels with a bound
	task automatic wait_outputs(input int count);
		int waited;
		waited = 0;
		while (out_cnt < count && waited < 2 * PIPE_DEPTH) begin
			@(posedge clk);
			waited++;
		end
		if (out_cnt < count) begin
			$display("Only %0d of %0d output pixels arrived in time", out_cnt, count);
			flow_errs++;
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		int errs;
		errs = total_errors() - errs_before;
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("Test %0d %s finished with %0d errors", tests_run, name, errs);
	endtask

	initial begin
		int errs;
		reset    = 1'b1;
		valid_in = 1'b0;
		pxl_in   = '0;
		clear_model();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		errs = total_errors();
		idle_cycles(IDLE_LEN);
		end_test("idle after reset", errs);

		errs = total_errors();
		clear_model();
		drive_samples(BURST_LEN);
		wait_outputs(expected_total(BURST_LEN));
		end_test("burst order and channel slots", errs);

		// Long gap sends the selector back to idle
		errs = total_errors();
		idle_cycles(GAP_LEN);
		clear_model();
		drive_samples(BURST_LEN);
		wait_outputs(expected_total(BURST_LEN));
		end_test("new burst after gap", errs);

		errs = total_errors();
		clear_model();
		drive_samples(PART_LEN);
		apply_reset(RESET_CYCLES);
		drive_samples(BURST_LEN);
		wait_outputs(expected_total(BURST_LEN));
		idle_cycles(PIPE_DEPTH);
		end_test("reset mid burst", errs);

		$display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			total_errors());
		if (total_errors() == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+test
design/conv_loop_pkg.sv
design/pixel_framer.sv
design/line_buffer.sv
design/channel_selector.sv
design/conv_loop_data_in.sv
test/conv_loop_data_in_tb.sv

//--- run.sh
#!/bin/sh
# Compile the testbench with Verilator and run it.
# Exit status is zero only when the pass line shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module conv_loop_data_in_tb \
	-o conv_loop_sim \
	&& ./obj_dir/conv_loop_sim | tee /dev/stderr | grep -q "^Done: no errors$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
